// File: Makefile
# Verilator build and run of the frame decoder testbench

LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_frame_dec -f frame_dec.f

run: compile
	./obj_dir/Vtb_frame_dec | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: frame_dec.f
+incdir+sim
hw/frame_dec_pkg.sv
hw/bloom_pkg.sv
hw/frame_sync.sv
hw/bloom_hash_gen.sv
hw/bloom_dec.sv
hw/symbol_lookup.sv
hw/frame_dec_top.sv
sim/tb_frame_dec.sv

// File: hw/bloom_dec.sv
/*
 * Bloom filter decoder: each of the 24 symbol bits is the AND of the
 * frame bits at K consecutive hash positions, bit 0 first
 */

`timescale 1ns/10ps

module bloom_dec #(
    parameter int K_HASHES = bloom_pkg::K_HASHES_DEFAULT
) (
    input  logic                      USER_CLK,
    input  logic                      SYSTEM_RESET,
    input  logic                      cs_i,
    input  frame_dec_pkg::frame_t     frame_i,          // Held stable while frame_ready_i
    input  logic                      frame_ready_i,
    input  logic                      byte_valid_i,     // Lookup finished the last symbol
    input  frame_dec_pkg::frame_pos_t hash_pos_i,
    output logic                      hash_restart_o,
    output logic                      hash_step_o,
    output logic                      frame_release_o,  // One-cycle pulse
    output bloom_pkg::symbol_t        symbol_o,
    output logic                      symbol_valid_o,   // One-cycle pulse, with release
    output logic                      busy_o
);

    localparam int KW = $clog2(K_HASHES + 1);
    localparam int BW = $clog2(bloom_pkg::SYMBOL_BITS);

    bloom_pkg::bloom_state_t state_q;
    logic [KW-1:0]           k_q;        // Hash index within the bit
    logic [BW-1:0]           bit_q;      // Symbol bit being decoded
    bloom_pkg::symbol_t      sym_q;
    logic                    release_q;
    logic                    valid_q;
    logic                    last_k;
    logic                    last_bit;

    assign last_k   = (k_q == KW'(K_HASHES - 1));
    assign last_bit = (bit_q == BW'(bloom_pkg::SYMBOL_BITS - 1));

    // ----------------------------------------
    // Hash generator control
    // ----------------------------------------
    assign hash_restart_o = (state_q == bloom_pkg::B_IDLE) && frame_ready_i;
    assign hash_step_o    = (state_q == bloom_pkg::B_HASH) && !(last_k && last_bit);

    // ----------------------------------------
    // Decode FSM
    // ----------------------------------------
    always_ff @(posedge USER_CLK)
    begin
        if (SYSTEM_RESET)
        begin
            state_q   <= bloom_pkg::B_IDLE;
            k_q       <= '0;
            bit_q     <= '0;
            release_q <= 1'b0;
            valid_q   <= 1'b0;
        end
        else if (cs_i)
        begin
            release_q <= 1'b0;  // Pulses by default
            valid_q   <= 1'b0;
            case (state_q)
                bloom_pkg::B_IDLE:
                begin
                    if (frame_ready_i)
                    begin
                        state_q <= bloom_pkg::B_HASH;  // Seed position valid next cycle
                        k_q     <= '0;
                        bit_q   <= '0;
                    end
                end
                bloom_pkg::B_HASH:
                begin
                    if (last_k)
                    begin
                        k_q <= '0;
                        if (last_bit)
                        begin
                            state_q   <= bloom_pkg::B_WAIT;
                            release_q <= 1'b1;  // Frame buffer free for the next one
                            valid_q   <= 1'b1;
                        end
                        else
                            bit_q <= bit_q + 1'b1;
                    end
                    else
                        k_q <= k_q + 1'b1;
                end
                bloom_pkg::B_WAIT:
                begin
                    if (byte_valid_i)
                        state_q <= bloom_pkg::B_IDLE;
                end
                default:
                    state_q <= bloom_pkg::B_IDLE;
            endcase
        end
    end

    // Symbol accumulator, all ones at start, any zero frame bit clears
    always_ff @(posedge USER_CLK)
    begin
        if (cs_i)
        begin
            if (state_q == bloom_pkg::B_IDLE && frame_ready_i)
                sym_q <= '1;
            else if (state_q == bloom_pkg::B_HASH)
                sym_q[bit_q] <= sym_q[bit_q] & frame_i[hash_pos_i];
        end
    end

    assign symbol_o        = sym_q;
    assign symbol_valid_o  = valid_q;
    assign frame_release_o = release_q;
    assign busy_o          = (state_q != bloom_pkg::B_IDLE);  // Rises the cycle after accept

endmodule

// File: hw/bloom_hash_gen.sv
/*
 * Frame bit position source for the Bloom decoder
 * Maximal-length LFSR, reloaded from a fixed seed for every frame
 */

`timescale 1ns/10ps

module bloom_hash_gen (
    input  logic                      USER_CLK,
    input  logic                      SYSTEM_RESET,
    input  logic                      cs_i,
    input  logic                      restart_i,  // Load seed, new frame
    input  logic                      step_i,     // Advance to next position
    output frame_dec_pkg::frame_pos_t pos_o       // Valid the cycle after restart or step
);

    frame_dec_pkg::frame_pos_t lfsr_q;

    // ----------------------------------------
    // Position register
    // ----------------------------------------
    always_ff @(posedge USER_CLK)
    begin
        if (SYSTEM_RESET)
        begin
            lfsr_q <= bloom_pkg::LFSR_SEED;
        end
        else if (cs_i)
        begin
            if (restart_i)
                lfsr_q <= bloom_pkg::LFSR_SEED;             // Same sequence every frame
            else if (step_i)
                lfsr_q <= bloom_pkg::lfsr_next(lfsr_q);
        end
    end

    // State is the position itself, no extra mapping
    assign pos_o = lfsr_q;

endmodule

// File: hw/bloom_pkg.sv
/*
 * Bloom code definitions: symbol expansion rule, position LFSR,
 * and the state encodings of the decoder and the lookup
 */

package bloom_pkg;

    localparam int SYMBOL_BITS      = 24;  // Expanded symbol width
    localparam int K_HASHES_DEFAULT = 5;   // Hash positions per symbol bit

    // Restart value of the position LFSR, must be nonzero
    localparam frame_dec_pkg::frame_pos_t LFSR_SEED = 10'h001;

    typedef logic [7:0]             byte_t;    // Decoded user byte
    typedef logic [SYMBOL_BITS-1:0] symbol_t;  // Expanded symbol

    // ----------------------------------------
    // FSM encodings
    // ----------------------------------------
    typedef enum logic [1:0] {
        B_IDLE,  // Waiting for an assembled frame
        B_HASH,  // ANDing frame bits into the symbol
        B_WAIT   // Symbol handed off, waiting for the byte
    } bloom_state_t;

    typedef enum logic {
        L_IDLE,    // No symbol pending
        L_SEARCH   // One candidate byte per cycle
    } lookup_state_t;

    // Byte to symbol, fields from the top: byte, inverted, bit-reversed
    // Never all zeros or all ones since byte and ~byte are both present
    function automatic symbol_t symbol_expand(input byte_t b);
        byte_t rev;
        for (int i = 0; i < 8; i++)
        begin
            rev[i] = b[7-i];  // Mirror bit order
        end
        return {b, ~b, rev};
    endfunction

    // Fibonacci LFSR, x^10 + x^7 + 1, period 1023
    // Each state is a frame bit position, position 0 is never produced
    function automatic frame_dec_pkg::frame_pos_t lfsr_next(
        input frame_dec_pkg::frame_pos_t s
    );
        return {s[8:0], s[9] ^ s[6]};
    endfunction

endpackage

// File: hw/frame_dec_pkg.sv
/*
 * Link framing definitions for the receive-side frame decoder
 * Word width, frame geometry and the sync pattern
 */

package frame_dec_pkg;

    // ----------------------------------------
    // Link geometry
    // ----------------------------------------
    localparam int WORD_BITS   = 32;                      // Received word width
    localparam int FRAME_BITS  = 1024;                    // Bloom filter payload size
    localparam int FRAME_WORDS = FRAME_BITS / WORD_BITS;  // 32 words per frame

    // Sync pattern that precedes every frame, any byte alignment
    localparam logic [WORD_BITS-1:0] SYNC_WORD_DEFAULT = 32'h1234_807F;

    // ----------------------------------------
    // Typed vectors
    // ----------------------------------------
    typedef logic [WORD_BITS-1:0]          rx_word_t;    // One link word
    typedef logic [FRAME_BITS-1:0]         frame_t;      // Assembled frame
    typedef logic [$clog2(FRAME_BITS)-1:0] frame_pos_t;  // Frame bit index

endpackage

// File: hw/frame_dec_top.sv
/*
 * Receive-side frame decoder top level
 * Sync search, Bloom decode, position generator and byte lookup
 */

`timescale 1ns/10ps

module frame_dec_top #(
    parameter frame_dec_pkg::rx_word_t SYNC_WORD = frame_dec_pkg::SYNC_WORD_DEFAULT,
    parameter int                      K_HASHES  = bloom_pkg::K_HASHES_DEFAULT
) (
    input  logic                    USER_CLK,
    input  logic                    SYSTEM_RESET,
    input  logic                    cs_i,
    input  frame_dec_pkg::rx_word_t rx_data_i,
    output logic                    synched_o,
    output logic                    busy_o,
    output bloom_pkg::byte_t        byte_o,
    output logic                    byte_valid_o,
    output logic [31:0]             frame_count_o
);

    // ----------------------------------------
    // Inter-block wires
    // ----------------------------------------
    frame_dec_pkg::frame_t     frame;          // Assembled frame, held until release
    logic                      frame_ready;
    logic                      frame_release;
    logic                      hash_restart;
    logic                      hash_step;
    frame_dec_pkg::frame_pos_t hash_pos;
    bloom_pkg::symbol_t        symbol;
    logic                      symbol_valid;

    frame_sync #(
        .SYNC_WORD (SYNC_WORD)
    ) frame_sync_i (
        .USER_CLK        (USER_CLK),
        .SYSTEM_RESET    (SYSTEM_RESET),
        .cs_i            (cs_i),
        .rx_data_i       (rx_data_i),
        .frame_release_i (frame_release),
        .frame_o         (frame),
        .frame_ready_o   (frame_ready),
        .synched_o       (synched_o)
    );

    bloom_hash_gen hash_gen_i (
        .USER_CLK     (USER_CLK),
        .SYSTEM_RESET (SYSTEM_RESET),
        .cs_i         (cs_i),
        .restart_i    (hash_restart),
        .step_i       (hash_step),
        .pos_o        (hash_pos)
    );

    bloom_dec #(
        .K_HASHES (K_HASHES)
    ) bloom_dec_i (
        .USER_CLK        (USER_CLK),
        .SYSTEM_RESET    (SYSTEM_RESET),
        .cs_i            (cs_i),
        .frame_i         (frame),
        .frame_ready_i   (frame_ready),
        .byte_valid_i    (byte_valid_o),   // Decoder waits on the lookup result
        .hash_pos_i      (hash_pos),
        .hash_restart_o  (hash_restart),
        .hash_step_o     (hash_step),
        .frame_release_o (frame_release),
        .symbol_o        (symbol),
        .symbol_valid_o  (symbol_valid),
        .busy_o          (busy_o)
    );

    symbol_lookup lookup_i (
        .USER_CLK       (USER_CLK),
        .SYSTEM_RESET   (SYSTEM_RESET),
        .cs_i           (cs_i),
        .symbol_i       (symbol),
        .symbol_valid_i (symbol_valid),
        .byte_o         (byte_o),
        .byte_valid_o   (byte_valid_o),
        .frame_count_o  (frame_count_o)
    );

endmodule

// File: hw/frame_sync.sv
/*
 * Sync word search over four byte alignments of a two-word window,
 * then assembly of the 1024-bit frame that follows the sync word
 */

`timescale 1ns/10ps

module frame_sync #(
    parameter frame_dec_pkg::rx_word_t SYNC_WORD = frame_dec_pkg::SYNC_WORD_DEFAULT
) (
    input  logic                    USER_CLK,
    input  logic                    SYSTEM_RESET,
    input  logic                    cs_i,             // Chip select, holds all state when low
    input  frame_dec_pkg::rx_word_t rx_data_i,        // Link word stream
    input  logic                    frame_release_i,  // Decoder is done with frame_o
    output frame_dec_pkg::frame_t   frame_o,
    output logic                    frame_ready_o,    // Level, high until release
    output logic                    synched_o         // Frame words being collected
);

    localparam int WB = frame_dec_pkg::WORD_BITS;

    logic [2*WB-1:0]                         win_q;      // Older word low, newer word high
    frame_dec_pkg::frame_t                   frame_q;
    logic                                    synched_q;
    logic                                    ready_q;
    logic [1:0]                              align_q;    // Latched byte offset index
    logic [$clog2(frame_dec_pkg::FRAME_WORDS)-1:0] cnt_q; // Frame words taken
    logic                                    hit;
    logic [1:0]                              hit_off;
    logic [$clog2(2*WB)-1:0]                 slice_lsb;  // Start bit of the aligned word

    // ----------------------------------------
    // Sync search
    // ----------------------------------------
    // Slices start at bits 8, 16, 24, 32 of the window
    // Offset 0 of the older word was already seen one word earlier
    always_comb
    begin
        hit     = 1'b0;
        hit_off = 2'd0;
        for (int i = 3; i >= 0; i--)  // Descending so the earliest offset wins
        begin
            if (win_q[8*i+8 +: WB] == SYNC_WORD)
            begin
                hit     = 1'b1;
                hit_off = 2'(i);
            end
        end
    end

    assign slice_lsb = {align_q, 3'b000} + 6'd8;  // 8 * (offset + 1)

    // ----------------------------------------
    // Window shift and frame assembly
    // ----------------------------------------
    always_ff @(posedge USER_CLK)
    begin
        if (SYSTEM_RESET)
        begin
            win_q     <= '0;
            synched_q <= 1'b0;
            ready_q   <= 1'b0;
            align_q   <= 2'd0;
            cnt_q     <= '0;
        end
        else if (cs_i)
        begin
            if (ready_q)
            begin
                // Frame held for the decoder, stream is dropped
                if (frame_release_i)
                    ready_q <= 1'b0;
            end
            else
            begin
                win_q <= {rx_data_i, win_q[2*WB-1:WB]};  // Newest word enters high
                if (synched_q)
                begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == frame_dec_pkg::FRAME_WORDS - 1)
                    begin
                        synched_q <= 1'b0;
                        ready_q   <= 1'b1;
                        win_q     <= '0;  // Stale frame bits must not match later
                    end
                end
                else if (hit)
                begin
                    synched_q <= 1'b1;  // Search suspended from here
                    align_q   <= hit_off;
                    cnt_q     <= '0;
                end
            end
        end
    end

    // Aligned word enters at the top, word 0 ends up in bits 31:0
    always_ff @(posedge USER_CLK)
    begin
        if (cs_i && !ready_q && synched_q)
            frame_q <= {win_q[slice_lsb +: WB], frame_q[frame_dec_pkg::FRAME_BITS-1:WB]};
    end

    assign frame_o       = frame_q;
    assign frame_ready_o = ready_q;
    assign synched_o     = synched_q;

endmodule

// File: hw/symbol_lookup.sv
/*
 * Reverse search from expanded symbol to byte, one candidate per cycle,
 * plus the running count of decoded frames
 */

`timescale 1ns/10ps

module symbol_lookup (
    input  logic               USER_CLK,
    input  logic               SYSTEM_RESET,
    input  logic               cs_i,
    input  bloom_pkg::symbol_t symbol_i,
    input  logic               symbol_valid_i,
    output bloom_pkg::byte_t   byte_o,
    output logic               byte_valid_o,   // One-cycle pulse per frame
    output logic [31:0]        frame_count_o
);

    bloom_pkg::lookup_state_t state_q;
    bloom_pkg::symbol_t       sym_q;      // Held symbol under search
    bloom_pkg::byte_t         cand_q;     // Candidate byte
    bloom_pkg::byte_t         byte_q;
    logic                     valid_q;
    logic [31:0]              count_q;
    logic                     done;

    // Match, or give up at 255, which also covers corrupt symbols
    assign done = (bloom_pkg::symbol_expand(cand_q) == sym_q) || (cand_q == 8'hFF);

    always_ff @(posedge USER_CLK)
    begin
        if (SYSTEM_RESET)
        begin
            state_q <= bloom_pkg::L_IDLE;
            valid_q <= 1'b0;
            count_q <= '0;
        end
        else if (cs_i)
        begin
            valid_q <= 1'b0;
            case (state_q)
                bloom_pkg::L_IDLE:
                begin
                    if (symbol_valid_i)
                    begin
                        state_q <= bloom_pkg::L_SEARCH;
                        sym_q   <= symbol_i;
                        cand_q  <= '0;  // Search from byte 0 up
                    end
                end
                default:
                begin
                    if (done)
                    begin
                        state_q <= bloom_pkg::L_IDLE;
                        byte_q  <= cand_q;
                        valid_q <= 1'b1;
                        count_q <= count_q + 1'b1;  // Same edge as byte_valid_o
                    end
                    else
                        cand_q <= cand_q + 1'b1;
                end
            endcase
        end
    end

    assign byte_o        = byte_q;
    assign byte_valid_o  = valid_q;
    assign frame_count_o = count_q;

endmodule

// File: sim/frame_enc_tasks.svh
/*
 * Testbench frame encoder: Bloom-encodes a byte into a frame and sends
 * the frame behind the sync word at a chosen byte offset
 */

`ifndef FRAME_ENC_TASKS_SVH
`define FRAME_ENC_TASKS_SVH

// K positions per set bit of the expanded symbol, same LFSR walk as the decoder
function automatic frame_dec_pkg::frame_t encode_byte(input bloom_pkg::byte_t b);
    frame_dec_pkg::frame_t     f;
    frame_dec_pkg::frame_pos_t pos;
    bloom_pkg::symbol_t        sym;
    f   = '0;
    pos = bloom_pkg::LFSR_SEED;
    sym = bloom_pkg::symbol_expand(b);
    for (int s = 0; s < bloom_pkg::SYMBOL_BITS; s++)
    begin
        for (int k = 0; k < K_HASHES; k++)
        begin
            if (sym[s])
                f[pos] = 1'b1;
            pos = bloom_pkg::lfsr_next(pos);  // Walk on for zero bits as well
        end
    end
    return f;
endfunction

// One word per cycle, 1 ns after the rising edge
task automatic drive_word(input frame_dec_pkg::rx_word_t w);
    @(posedge USER_CLK);
    #1;
    cs      = 1'b1;
    rx_data = w;
endtask

// Filler bytes, sync bytes low first, frame bytes, filler up to a word edge
task automatic send_frame(input frame_dec_pkg::frame_t f, input int off,
                          input int pause_at, input int pause_len);
    logic [7:0]  bytes[$];
    logic [31:0] r;
    int          s_last;
    s_last = (off + 3) / 4;  // Word holding the last sync byte
    for (int i = 0; i < off; i++)
    begin
        r = $random(seed);
        bytes.push_back(r[7:0] & 8'hBF);
    end
    for (int i = 0; i < 4; i++)
        bytes.push_back(SYNC[8*i +: 8]);
    for (int i = 0; i < frame_dec_pkg::FRAME_BITS / 8; i++)
        bytes.push_back(f[8*i +: 8]);
    while (bytes.size() % 4 != 0)
    begin
        r = $random(seed);
        bytes.push_back(r[7:0] & 8'hBF);
    end
    for (int n = 0; n < bytes.size() / 4; n++)
    begin
        if (n == pause_at)
            hold_cs_low(pause_len);  // Stream paused with the DUT
        drive_word({bytes[4*n+3], bytes[4*n+2], bytes[4*n+1], bytes[4*n]});
        // Sync seen on edge s_last, synched one edge later
        assert (synched == (n >= s_last + 2)) else
        begin
            errors++;
            $display("FAILED at %0t: synched_o %b at frame stream word %0d, offset %0d",
                     $time, synched, n, off);
        end
    end
    frames_sent++;
endtask

`endif

// File: sim/tb_frame_dec.sv
/*
 * Testbench for the frame decoder: encoded frames at all byte offsets,
 * flat frames, a chip-select stall and two frames in flight
 */

`timescale 1ns/10ps

module tb_frame_dec;

    localparam int                      K_HASHES = bloom_pkg::K_HASHES_DEFAULT;
    localparam frame_dec_pkg::rx_word_t SYNC     = frame_dec_pkg::SYNC_WORD_DEFAULT;
    localparam int                      TIMEOUT  = 2000;  // Cycles per wait loop
    localparam bloom_pkg::byte_t        FIXED_BYTES [4] = '{8'h00, 8'h5A, 8'hC3, 8'hFF};

    logic                    USER_CLK;
    logic                    SYSTEM_RESET;
    logic                    cs;
    frame_dec_pkg::rx_word_t rx_data;
    logic                    synched;
    logic                    busy;
    bloom_pkg::byte_t        rx_byte;
    logic                    byte_valid;
    logic [31:0]             frame_count;

    integer                  seed = 32'h0f79e31e;
    int                      errors = 0;
    int                      pulses = 0;       // byte_valid_o pulses since reset
    int                      frames_sent = 0;
    bloom_pkg::byte_t        got_bytes[$];     // Decoded bytes not yet checked

    `include "frame_enc_tasks.svh"

    frame_dec_top #(
        .SYNC_WORD (SYNC),
        .K_HASHES  (K_HASHES)
    ) dut_i (
        .USER_CLK      (USER_CLK),
        .SYSTEM_RESET  (SYSTEM_RESET),
        .cs_i          (cs),
        .rx_data_i     (rx_data),
        .synched_o     (synched),
        .busy_o        (busy),
        .byte_o        (rx_byte),
        .byte_valid_o  (byte_valid),
        .frame_count_o (frame_count)
    );

    initial
    begin
        USER_CLK = 1'b0;
        forever #5 USER_CLK = ~USER_CLK;  // 100 MHz
    end

    // Byte collector, mid-cycle
    always @(negedge USER_CLK)
    begin
        if (byte_valid)
        begin
            pulses++;
            got_bytes.push_back(rx_byte);
            assert (frame_count == pulses) else
            begin
                errors++;
                $display("FAILED at %0t: frame_count_o %0d after %0d byte pulses",
                         $time, frame_count, pulses);
            end
        end
    end

    // ----------------------------------------
    // Stream helpers
    // ----------------------------------------
    task automatic drive_filler();
        logic [31:0] r;
        r = $random(seed);
        drive_word(r & 32'hBFBF_BFBF);  // Never an 8'h7F byte, so no sync start
    endtask

    task automatic send_idle_filler(input int n);
        for (int i = 0; i < n; i++)
        begin
            drive_filler();
            assert (!synched) else
            begin
                errors++;
                $display("FAILED at %0t: synched_o high during filler", $time);
            end
        end
    endtask

    // All outputs must hold while the chip is deselected
    task automatic hold_cs_low(input int cycles);
        logic [42:0] snap;
        @(posedge USER_CLK);
        #1;
        cs   = 1'b0;
        snap = {synched, busy, byte_valid, rx_byte, frame_count};
        for (int i = 0; i < cycles; i++)
        begin
            @(posedge USER_CLK);
            #1;
            assert ({synched, busy, byte_valid, rx_byte, frame_count} == snap) else
            begin
                errors++;
                $display("FAILED at %0t: outputs moved while cs_i low", $time);
            end
        end
    endtask

    task automatic expect_byte(input bloom_pkg::byte_t exp);
        int               n;
        bloom_pkg::byte_t got;
        n = 0;
        while (got_bytes.size() == 0 && n < TIMEOUT)
        begin
            drive_filler();
            n++;
        end
        if (got_bytes.size() == 0)
        begin
            errors++;
            $display("Timed out at %0t waiting for decoded byte %h", $time, exp);
        end
        else
        begin
            got = got_bytes.pop_front();
            assert (got == exp) else
            begin
                errors++;
                $display("FAILED at %0t: byte_o %h, expected %h", $time, got, exp);
            end
        end
    endtask

    // Frame buffer handed back, so the next frame is not dropped
    task automatic wait_frame_release();
        int n;
        n = 0;
        while (!dut_i.frame_ready && n < TIMEOUT)
        begin
            drive_filler();
            n++;
        end
        if (n >= TIMEOUT)
        begin
            errors++;
            $display("Timed out at %0t waiting for an assembled frame", $time);
        end
        n = 0;
        while (dut_i.frame_ready && n < TIMEOUT)
        begin
            drive_filler();
            n++;
        end
        if (n >= TIMEOUT)
        begin
            errors++;
            $display("Timed out at %0t waiting for the frame release", $time);
        end
    endtask

    // Bytes pending until the target pulse count are covered by busy_o
    task automatic watch_busy(input int target);
        int   n;
        logic last_valid;
        n          = 0;
        last_valid = 1'b0;
        while (pulses < target && n < TIMEOUT)
        begin
            drive_filler();
            n++;
            // Decoder spends the cycle after a byte idle, then takes the held frame
            assert (busy || byte_valid || last_valid || pulses >= target) else
            begin
                errors++;
                $display("FAILED at %0t: busy_o low with a byte pending", $time);
            end
            last_valid = byte_valid;
        end
        if (pulses < target)
        begin
            errors++;
            $display("Timed out at %0t waiting for two decoded bytes", $time);
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial
    begin
        logic [31:0]      r;
        bloom_pkg::byte_t b;
        SYSTEM_RESET = 1'b1;
        cs           = 1'b1;
        rx_data      = '0;
        repeat (16) @(posedge USER_CLK);
        #1;
        SYSTEM_RESET = 1'b0;
        assert (!synched && !busy && !byte_valid && frame_count == 0) else
        begin
            errors++;
            $display("FAILED at %0t: outputs not idle after reset", $time);
        end

        send_idle_filler(40);  // Random stream alone never syncs

        for (int i = 0; i < 12; i++)  // Every byte offset, fixed then random bytes
        begin
            r = $random(seed);
            b = (i < 4) ? FIXED_BYTES[i] : r[7:0];
            send_frame(encode_byte(b), i % 4, -1, 0);
            expect_byte(b);
            send_idle_filler(3);
        end

        send_frame('0, 1, -1, 0);  // Flat frames match no byte
        expect_byte(8'hFF);
        send_frame('1, 3, -1, 0);
        expect_byte(8'hFF);

        send_frame(encode_byte(8'h96), 2, 14, 25);  // Stall mid-frame
        expect_byte(8'h96);

        // Slow lookup for the first byte, so both frames are in flight
        send_frame(encode_byte(8'hF0), 2, -1, 0);
        wait_frame_release();
        send_frame(encode_byte(8'h3C), 1, -1, 0);
        watch_busy(pulses + 2);
        expect_byte(8'hF0);
        expect_byte(8'h3C);

        send_idle_filler(10);
        assert (pulses == frames_sent && frame_count == pulses && got_bytes.size() == 0) else
        begin
            errors++;
            $display("FAILED at %0t: %0d byte pulses for %0d frames", $time, pulses, frames_sent);
        end

        $display("errors: %0d  frames sent: %0d  bytes decoded: %0d", errors, frames_sent, pulses);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule
